// File: common/cpu_types_pkg.sv
package cpu_types_pkg;

    // basic data word
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // data cache address split
    localparam int DTAG_W = 26;
    localparam int DIDX_W = 3;
    localparam int DBLK_W = 1;
    localparam int DBYT_W = 2;

    // tag | index | word in block | byte in word
    typedef struct packed {
        logic [DTAG_W-1:0] tag;
        logic [DIDX_W-1:0] idx;
        logic [DBLK_W-1:0] blkoff;
        logic [DBYT_W-1:0] bytoff;
    } dcachef_t;

    // operation carried with each memory request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

// File: dcache/dcache.sv
`timescale 1ns/1ns

module dcache (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   dmemren,
    input  logic                   dmemwen,
    input  logic                   halt,
    input  cpu_types_pkg::word_t   dmemaddr,
    input  cpu_types_pkg::word_t   dmemstore,
    output logic                   dhit,
    output logic                   flushed,
    output cpu_types_pkg::word_t   dmemload,
    output logic                   mem_req,
    output cpu_types_pkg::mem_op_t mem_op,
    output cpu_types_pkg::word_t   mem_addr,
    output cpu_types_pkg::word_t   mem_wdata,
    input  logic                   mem_ack,
    input  cpu_types_pkg::word_t   mem_rdata
);

    import cpu_types_pkg::*;

    localparam int NWAYS  = 2;
    localparam int NSETS  = 1 << DIDX_W;
    localparam int NWORDS = 1 << DBLK_W;

    typedef enum logic [3:0] {
        S_COMPARE,
        S_WB0,
        S_WB1,
        S_ALLOC0,
        S_ALLOC1,
        S_FLUSH_SCAN,
        S_FLUSH_WR0,
        S_FLUSH_WR1,
        S_DONE
    } state_t;

    // frame control bits per way and index
    logic [NWAYS-1:0][NSETS-1:0] valid;
    logic [NWAYS-1:0][NSETS-1:0] dirty;
    logic [NSETS-1:0]            lru;

    // frame payload
    logic [DTAG_W-1:0] tags [NWAYS][NSETS];
    word_t             blk_data [NWAYS][NSETS][NWORDS];

    state_t            state;
    state_t            next_state;
    dcachef_t          req_addr;
    dcachef_t          mem_fmt;
    logic [NWAYS-1:0]  way_hit;
    logic              hit;
    logic              hit_way;
    logic              active;
    logic              victim;
    logic              xfer_done;
    logic              mem_phase;
    logic [DBLK_W-1:0] mem_word;
    logic [DIDX_W:0]   flush_cnt;
    logic              flush_way;
    logic [DIDX_W-1:0] flush_idx;
    logic              flush_last;

    assign req_addr = dmemaddr;
    assign active   = dmemren || dmemwen;

    always_comb begin
        for (int w = 0; w < NWAYS; w++) begin
            way_hit[w] = valid[w][req_addr.idx] && (tags[w][req_addr.idx] == req_addr.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign victim  = lru[req_addr.idx];

    // hit answered in the same cycle
    assign dhit     = (state == S_COMPARE) && !halt && active && hit;
    assign dmemload = dmemwen ? dmemstore : blk_data[hit_way][req_addr.idx][req_addr.blkoff];
    assign flushed  = (state == S_DONE);

    // flush walks way 0 then way 1
    assign flush_way  = flush_cnt[DIDX_W];
    assign flush_idx  = flush_cnt[DIDX_W-1:0];
    assign flush_last = &flush_cnt;

    assign mem_phase = state inside {S_WB0, S_WB1, S_ALLOC0, S_ALLOC1, S_FLUSH_WR0, S_FLUSH_WR1};
    assign mem_word  = DBLK_W'(state inside {S_WB1, S_ALLOC1, S_FLUSH_WR1});
    assign xfer_done = mem_req && mem_ack;

    always_comb begin
        next_state = state;
        case (state)
            S_COMPARE: begin
                if (halt) begin
                    next_state = S_FLUSH_SCAN;
                end else if (active && !hit) begin
                    next_state = dirty[victim][req_addr.idx] ? S_WB0 : S_ALLOC0;
                end
            end
            S_WB0:       if (xfer_done) next_state = S_WB1;
            S_WB1:       if (xfer_done) next_state = S_ALLOC0;
            S_ALLOC0:    if (xfer_done) next_state = S_ALLOC1;
            // answer goes out through compare once the frame is filled
            S_ALLOC1:    if (xfer_done) next_state = S_COMPARE;
            S_FLUSH_SCAN: begin
                if (dirty[flush_way][flush_idx]) begin
                    next_state = S_FLUSH_WR0;
                end else if (flush_last) begin
                    next_state = S_DONE;
                end
            end
            S_FLUSH_WR0: if (xfer_done) next_state = S_FLUSH_WR1;
            // back to scan which now sees the frame clean
            S_FLUSH_WR1: if (xfer_done) next_state = S_FLUSH_SCAN;
            S_DONE:      next_state = S_DONE;
            default:     next_state = S_COMPARE;
        endcase
    end

    // memory request fields held by the state while req is up
    always_comb begin
        mem_fmt   = '0;
        mem_op    = MEM_READ;
        mem_wdata = '0;
        case (state)
            S_WB0, S_WB1: begin
                mem_op         = MEM_WRITE;
                mem_fmt.tag    = tags[victim][req_addr.idx];
                mem_fmt.idx    = req_addr.idx;
                mem_fmt.blkoff = mem_word;
                mem_wdata      = blk_data[victim][req_addr.idx][mem_word];
            end
            S_ALLOC0, S_ALLOC1: begin
                mem_fmt.tag    = req_addr.tag;
                mem_fmt.idx    = req_addr.idx;
                mem_fmt.blkoff = mem_word;
            end
            S_FLUSH_WR0, S_FLUSH_WR1: begin
                mem_op         = MEM_WRITE;
                mem_fmt.tag    = tags[flush_way][flush_idx];
                mem_fmt.idx    = flush_idx;
                mem_fmt.blkoff = mem_word;
                mem_wdata      = blk_data[flush_way][flush_idx][mem_word];
            end
            default: begin
                mem_op = MEM_READ;
            end
        endcase
    end

    assign mem_addr = mem_fmt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= S_COMPARE;
            valid     <= '0;
            dirty     <= '0;
            lru       <= '0;
            flush_cnt <= '0;
        end else begin
            state <= next_state;
            if (dhit) begin
                // point replacement at the other way
                lru[req_addr.idx] <= ~hit_way;
                if (dmemwen) begin
                    dirty[hit_way][req_addr.idx] <= 1'b1;
                end
            end
            if (state == S_ALLOC1 && xfer_done) begin
                valid[victim][req_addr.idx] <= 1'b1;
                dirty[victim][req_addr.idx] <= 1'b0;
            end
            if (state == S_FLUSH_WR1 && xfer_done) begin
                dirty[flush_way][flush_idx] <= 1'b0;
            end
            if (state == S_FLUSH_SCAN && !dirty[flush_way][flush_idx] && !flush_last) begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    // four-phase requester waits for ack low before a new req
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_req <= 1'b0;
        end else if (xfer_done) begin
            mem_req <= 1'b0;
        end else if (mem_phase && !mem_ack) begin
            mem_req <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (dhit && dmemwen) begin
            blk_data[hit_way][req_addr.idx][req_addr.blkoff] <= dmemstore;
        end
        if (xfer_done && (state inside {S_ALLOC0, S_ALLOC1})) begin
            blk_data[victim][req_addr.idx][mem_word] <= mem_rdata;
        end
        if (xfer_done && state == S_ALLOC1) begin
            tags[victim][req_addr.idx] <= req_addr.tag;
        end
    end

    // request must stay up and unchanged until the memory answers
    a_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr) && $stable(mem_op)))
        else $error("mem_req dropped or changed before mem_ack");

    a_no_req_on_ack: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(mem_req) |-> !$past(mem_ack))
        else $error("mem_req raised while mem_ack still high");

    // flushed is sticky until reset
    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else $error("flushed fell without reset");

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int MEM_LATENCY = 2,
    parameter int RAM_ADDR_W  = 10
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   mem_req,
    input  cpu_types_pkg::mem_op_t mem_op,
    input  cpu_types_pkg::word_t   mem_addr,
    input  cpu_types_pkg::word_t   mem_wdata,
    output logic                   mem_ack,
    output cpu_types_pkg::word_t   mem_rdata
);

    import cpu_types_pkg::*;

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);
    localparam int DEPTH = 1 << RAM_ADDR_W;

    word_t                 mem [DEPTH];
    logic [CNT_W-1:0]      wait_cnt;
    logic [RAM_ADDR_W-1:0] word_addr;
    logic                  respond;

    // word index, byte offset dropped
    assign word_addr = mem_addr[RAM_ADDR_W+1:2];
    assign respond   = mem_req && !mem_ack && (wait_cnt == CNT_W'(MEM_LATENCY - 1));

    // contents start at zero and survive reset
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_ack  <= 1'b0;
            wait_cnt <= '0;
        end else if (respond) begin
            mem_ack  <= 1'b1;
            wait_cnt <= '0;
        end else if (mem_req && !mem_ack) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    // access lands on the edge that raises ack
    always_ff @(posedge CLK) begin
        if (respond) begin
            if (mem_op == MEM_WRITE) begin
                mem[word_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[word_addr];
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(mem_ack) |-> $past(mem_req))
        else $error("mem_ack rose without mem_req");

    // cache addresses must fit this memory and be word aligned
    a_addr_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        mem_req |-> ((mem_addr >> (RAM_ADDR_W + 2)) == '0 && mem_addr[1:0] == 2'b00))
        else $error("mem_addr out of range or unaligned");

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
    parameter int MEM_LATENCY = 2,
    parameter int RAM_ADDR_W  = 10
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemren,
    input  logic                 dmemwen,
    input  cpu_types_pkg::word_t dmemaddr,
    input  cpu_types_pkg::word_t dmemstore,
    input  logic                 halt,
    output logic                 dhit,
    output cpu_types_pkg::word_t dmemload,
    output logic                 flushed
);

    import cpu_types_pkg::*;

    // cache to memory link
    logic    mem_req;
    logic    mem_ack;
    mem_op_t mem_op;
    word_t   mem_addr;
    word_t   mem_wdata;
    word_t   mem_rdata;

    dcache dcache0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .halt      (halt),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dhit      (dhit),
        .flushed   (flushed),
        .dmemload  (dmemload),
        .mem_req   (mem_req),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    data_ram #(
        .MEM_LATENCY (MEM_LATENCY),
        .RAM_ADDR_W  (RAM_ADDR_W)
    ) ram0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_req   (mem_req),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: bench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    import cpu_types_pkg::*;

    localparam int MEM_LATENCY   = 2;
    localparam int RAM_ADDR_W    = 10;
    localparam int HIT_TIMEOUT   = 8 * (MEM_LATENCY + 3) + 20;
    localparam int FLUSH_TIMEOUT = 40 * (MEM_LATENCY + 3) + 100;
    localparam int NUM_RANDOM    = 300;

    // tags stay below 64 so every address fits a 1K word memory
    localparam logic [DTAG_W-1:0] TAG_POOL [4] = '{26'd3, 26'd12, 26'd29, 26'd47};
    localparam logic [DIDX_W-1:0] IDX_POOL [3] = '{3'd0, 3'd2, 3'd5};

    logic  CLK = 1'b0;
    logic  nRST;
    logic  dmemren;
    logic  dmemwen;
    logic  halt;
    word_t dmemaddr;
    word_t dmemstore;
    logic  dhit;
    word_t dmemload;
    logic  flushed;

    integer seed = 32'hde67;

    // dhit at the first falling edge of the latest access
    logic first_hit;

    // reference memory with unwritten words read as zero
    word_t model [word_t];

    dcache_top #(
        .MEM_LATENCY (MEM_LATENCY),
        .RAM_ADDR_W  (RAM_ADDR_W)
    ) dut0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed)
    );

    always #50 CLK = ~CLK;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t make_addr(input logic [DTAG_W-1:0] tag,
                                        input logic [DIDX_W-1:0] idx,
                                        input logic [DBLK_W-1:0] blk);
        dcachef_t a;
        a        = '0;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blk;
        return a;
    endfunction

    function automatic word_t model_value(input word_t addr);
        if (model.exists(addr)) begin
            return model[addr];
        end else begin
            return '0;
        end
    endfunction

    task automatic apply_reset();
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        #10;
        nRST = 1'b1;
    endtask

    // hold the request until dhit is seen at a falling edge
    task automatic do_access(input logic is_write, input word_t addr, input word_t data,
                             output word_t load);
        int cycles;
        @(posedge CLK);
        #10;
        dmemren   = !is_write;
        dmemwen   = is_write;
        dmemaddr  = addr;
        dmemstore = data;
        cycles    = 0;
        @(negedge CLK);
        first_hit = dhit;
        while (!dhit) begin
            if (cycles >= HIT_TIMEOUT) begin
                $display("timeout: no dhit for address %h", addr);
                stop_run();
            end else begin
                cycles++;
                @(negedge CLK);
            end
        end
        load = dmemload;
    endtask

    task automatic do_read(input word_t addr, input logic must_hit);
        word_t load;
        do_access(1'b0, addr, '0, load);
        if (must_hit) begin
            // block is resident so the answer comes in the request cycle
            check_value("dhit", word_t'(1), word_t'(first_hit));
        end
        check_value("dmemload", model_value(addr), load);
    endtask

    task automatic do_write(input word_t addr, input word_t data);
        word_t load;
        do_access(1'b1, addr, data, load);
        // write echoes its store data
        check_value("dmemload", data, load);
        model[addr] = data;
    endtask

    task automatic go_idle();
        @(posedge CLK);
        #10;
        dmemren = 1'b0;
        dmemwen = 1'b0;
    endtask

    task automatic flush_and_hold();
        int cycles;
        @(posedge CLK);
        #10;
        dmemren = 1'b0;
        dmemwen = 1'b0;
        halt    = 1'b1;
        cycles  = 0;
        @(negedge CLK);
        while (!flushed) begin
            if (cycles >= FLUSH_TIMEOUT) begin
                $display("timeout: flushed never rose after halt");
                stop_run();
            end else begin
                cycles++;
                @(negedge CLK);
            end
        end
        // must stay up while halt is held
        repeat (6) begin
            @(negedge CLK);
            check_value("flushed", word_t'(1), word_t'(flushed));
        end
    endtask

    initial begin
        word_t addr;
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        apply_reset();

        // mixed traffic over a small address pool
        repeat (NUM_RANDOM) begin
            addr = make_addr(TAG_POOL[rand_below(4)], IDX_POOL[rand_below(3)],
                             DBLK_W'(rand_below(2)));
            if (rand_below(2) == 1) begin
                do_write(addr, $random(seed));
                do_read(addr, 1'b1);
            end else begin
                do_read(addr, 1'b0);
            end
        end

        // four tags on one index force dirty evictions
        for (int t = 0; t < 4; t++) begin
            do_write(make_addr(TAG_POOL[t], 3'd4, 1'b0), $random(seed));
        end
        for (int t = 0; t < 4; t++) begin
            do_read(make_addr(TAG_POOL[t], 3'd4, 1'b0), 1'b0);
        end

        // word 1 written and then both words of the block read back
        do_write(make_addr(TAG_POOL[0], 3'd4, 1'b1), $random(seed));
        do_read(make_addr(TAG_POOL[0], 3'd4, 1'b0), 1'b1);
        do_read(make_addr(TAG_POOL[0], 3'd4, 1'b1), 1'b1);

        flush_and_hold();

        // reset clears the cache but not the memory
        @(posedge CLK);
        #10;
        halt = 1'b0;
        apply_reset();
        @(negedge CLK);
        check_value("flushed", word_t'(0), word_t'(flushed));

        foreach (model[a]) begin
            do_read(a, 1'b0);
        end
        go_idle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verilog.f
common/cpu_types_pkg.sv
dcache/dcache.sv
logic/data_ram.sv
logic/dcache_top.sv
bench/dcache_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = dcache_tb
RTL_TOP    = dcache_top
FILELIST   = verilog.f
OBJDIR     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
